//--- hw/sifhPkg.sv
package sifhPkg;

    // raw timing code width
    localparam int codeW = 10;
    // bin address width, one histogram holds 2**binW bins
    localparam int binW = 5;
    localparam int numBins = 1 << binW;

    // bin counters saturate at cntMax
    localparam int cntW = 8;
    localparam int cntMax = (1 << cntW) - 1;

    // codes accepted per stage, larger than cntMax on purpose
    localparam int acqLen = 300;
    localparam int sampleW = $clog2(acqLen + 1);

    // right shift from raw code to coarse bin
    localparam int coarseShift = codeW - binW;

    // fine window sits this far below the coarse peak bin start
    localparam int halfWin = 16;
    // last start that still keeps the whole window inside the code range
    localparam int maxStart = (1 << codeW) - numBins;

    // fine window bounds, both inclusive
    typedef struct packed {
        logic [codeW-1:0] thMinus;
        logic [codeW-1:0] thPositive;
    } window_t;

    // result of one coarse plus fine pass
    typedef struct packed {
        logic [binW-1:0]  peakCH;
        logic [binW-1:0]  peakFH;
        logic [codeW-1:0] peakCode;
    } peakResult_t;

endpackage

//--- hw/binMapper.sv
`timescale 1ns/1ps

module binMapper (
    input  logic [sifhPkg::codeW-1:0] roughData,
    input  logic                      wrEn,
    input  logic                      hisNum,
    input  sifhPkg::window_t          window,
    output logic [sifhPkg::binW-1:0]  binAddr,
    output logic                      binHit
);
    import sifhPkg::*;

    logic [codeW-1:0] fineOffset;
    logic [codeW-1:0] coarseCode;
    logic             inWindow;

    // code distance from the window start
    assign fineOffset = roughData - window.thMinus;

    // upper bits select the coarse bin
    assign coarseCode = roughData >> coarseShift;

    // both window bounds inclusive
    assign inWindow = (roughData >= window.thMinus) && (roughData <= window.thPositive);

    always_comb begin
        if (hisNum) begin
            // fine stage, one code per bin
            binAddr = fineOffset[binW-1:0];
            // codes outside the window are dropped here only
            binHit = wrEn && inWindow;
        end else begin
            // coarse stage, every strobe lands somewhere
            binAddr = coarseCode[binW-1:0];
            binHit = wrEn;
        end
    end

endmodule

//--- hw/histogramBuilder.sv
`timescale 1ns/1ps

module histogramBuilder (
    input  logic                     clk,
    input  logic                     rstN,
    input  logic                     wrEn,
    input  logic [sifhPkg::binW-1:0] binAddr,
    input  logic                     binHit,
    input  sifhPkg::window_t         window,
    output logic                     busy,
    output logic                     hisNum,
    output logic [sifhPkg::binW-1:0] peakCH,
    output logic                     peakDone,
    output logic                     resultValid,
    output sifhPkg::peakResult_t     result
);
    import sifhPkg::*;

    // collect -> scan -> report -> release -> collect
    typedef enum logic [1:0] {
        stCollect,
        stScan,
        stReport,
        stRelease
    } state_t;

    state_t             state;
    logic [cntW-1:0]    binCnt [numBins];
    logic [sampleW-1:0] sampleCnt;
    logic [binW-1:0]    scanIdx;
    logic [cntW-1:0]    scanCnt;
    logic [cntW-1:0]    maxCnt;
    logic [binW-1:0]    maxIdx;
    logic               accept;
    logic               lastSample;
    logic               lastBin;

    // anything but collect blocks new codes
    assign busy = (state != stCollect);
    assign accept = wrEn && (state == stCollect);
    assign lastSample = (sampleCnt == sampleW'(acqLen - 1));
    assign lastBin = (scanIdx == binW'(numBins - 1));

    // bin under the scan pointer
    assign scanCnt = binCnt[scanIdx];

    // bin counters
    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < numBins; i++) begin
                binCnt[i] <= '0;
            end
        end else if (state == stScan) begin
            // clear as read, so the next stage starts empty
            binCnt[scanIdx] <= '0;
        end else if (accept && binHit && (binCnt[binAddr] != cntW'(cntMax))) begin
            // saturating increment
            binCnt[binAddr] <= binCnt[binAddr] + 1'b1;
        end
    end

    // stage control
    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= stCollect;
            sampleCnt <= '0;
            scanIdx <= '0;
            hisNum <= 1'b0;
            peakDone <= 1'b0;
            resultValid <= 1'b0;
        end else begin
            // pulses last one cycle
            peakDone <= 1'b0;
            resultValid <= 1'b0;
            case (state)
                stCollect: begin
                    // out-of-window strobes still count toward acqLen
                    if (accept) begin
                        if (lastSample) begin
                            sampleCnt <= '0;
                            scanIdx <= '0;
                            state <= stScan;
                        end else begin
                            sampleCnt <= sampleCnt + 1'b1;
                        end
                    end
                end
                stScan: begin
                    // one bin per cycle
                    scanIdx <= scanIdx + 1'b1;
                    if (lastBin) begin
                        state <= stReport;
                    end
                end
                stReport: begin
                    peakDone <= !hisNum;
                    resultValid <= hisNum;
                    state <= stRelease;
                end
                stRelease: begin
                    // swap stage as busy drops
                    hisNum <= !hisNum;
                    state <= stCollect;
                end
                default: begin
                    state <= stCollect;
                end
            endcase
        end
    end

    // running maximum and stored peaks
    always_ff @(posedge clk) begin
        if (state == stCollect) begin
            maxCnt <= '0;
            maxIdx <= '0;
        end else if ((state == stScan) && (scanCnt > maxCnt)) begin
            // strict compare, ties keep the lower index
            maxCnt <= scanCnt;
            maxIdx <= scanIdx;
        end
        if (state == stReport) begin
            if (!hisNum) begin
                peakCH <= maxIdx;
            end else begin
                result.peakCH <= peakCH;
                result.peakFH <= maxIdx;
                // fine bins are one code wide
                result.peakCode <= window.thMinus + codeW'(maxIdx);
            end
        end
    end

endmodule

//--- hw/windowCalc.sv
`timescale 1ns/1ps

module windowCalc (
    input  logic                     clk,
    input  logic                     rstN,
    input  logic [sifhPkg::binW-1:0] peakCH,
    input  logic                     peakDone,
    output sifhPkg::window_t         window
);
    import sifhPkg::*;

    // two spare bits so the subtraction can go negative
    logic signed [codeW+1:0] binStart;
    logic signed [codeW+1:0] rawStart;
    logic [codeW-1:0]        winStart;

    // first code of the coarse peak bin
    assign binStart = $signed({2'b00, peakCH, {coarseShift{1'b0}}});
    assign rawStart = binStart - (codeW + 2)'(halfWin);

    // keep the window inside the code range
    always_comb begin
        if (rawStart < 0) begin
            winStart = '0;
        end else if (rawStart > maxStart) begin
            winStart = codeW'(maxStart);
        end else begin
            winStart = rawStart[codeW-1:0];
        end
    end

    // held until the next coarse peak
    always_ff @(posedge clk) begin
        if (!rstN) begin
            window.thMinus <= '0;
            window.thPositive <= codeW'(numBins - 1);
        end else if (peakDone) begin
            window.thMinus <= winStart;
            window.thPositive <= winStart + codeW'(numBins - 1);
        end
    end

endmodule

//--- hw/sifhTop.sv
`timescale 1ns/1ps

module sifhTop (
    input  logic                      clk,
    input  logic                      rstN,
    input  logic                      wrEn,
    input  logic [sifhPkg::codeW-1:0] roughData,
    output logic                      busy,
    output logic                      hisNum,
    output logic                      resultValid,
    output sifhPkg::peakResult_t      result
);
    import sifhPkg::*;

    window_t         window;
    logic [binW-1:0] binAddr;
    logic            binHit;
    logic [binW-1:0] peakCH;
    logic            peakDone;

    // code to bin, drops fine codes outside the window
    binMapper binMapperInst (
        .roughData(roughData),
        .wrEn(wrEn),
        .hisNum(hisNum),
        .window(window),
        .binAddr(binAddr),
        .binHit(binHit)
    );

    // counters, stage FSM and peak scan
    histogramBuilder histogramBuilderInst (
        .clk(clk),
        .rstN(rstN),
        .wrEn(wrEn),
        .binAddr(binAddr),
        .binHit(binHit),
        .window(window),
        .busy(busy),
        .hisNum(hisNum),
        .peakCH(peakCH),
        .peakDone(peakDone),
        .resultValid(resultValid),
        .result(result)
    );

    // fine window from the coarse peak
    windowCalc windowCalcInst (
        .clk(clk),
        .rstN(rstN),
        .peakCH(peakCH),
        .peakDone(peakDone),
        .window(window)
    );

endmodule

//--- tests/sifhRunTable.svh
`ifndef SIFH_RUN_TABLE_SVH
`define SIFH_RUN_TABLE_SVH

// one row plays one coarse stage and one fine stage
//   target    code the stimulus is centred on
//   spread    random offset range, plus or minus
//   noisePct  share of uniform random codes, percent
//   altStep   odd strobes go to target plus altStep, 0 for none
//   inject    keep strobing while busy is high
typedef struct packed {
    int target;
    int spread;
    int noisePct;
    int altStep;
    bit inject;
} runRow_t;

localparam int numRuns = 6;

localparam runRow_t runTable [numRuns] = '{
    // narrow pulse mid-range where both stages saturate
    '{490, 0, 0, 0, 1'b0},
    // low edge where the window start clamps to 0
    '{5, 3, 0, 0, 1'b0},
    // top coarse bin with codes above the window
    '{1020, 3, 0, 0, 1'b0},
    // noisy so many fine codes fall outside the window
    '{680, 4, 40, 0, 1'b0},
    // two coarse bins with 150 codes each
    '{320, 0, 0, 32, 1'b0},
    // strobes keep coming during the scan
    '{230, 2, 10, 0, 1'b1}
};

// code range and bin geometry
localparam int codeSpan = 1024;
localparam int coarseSpan = 32;
localparam int winLen = 32;
localparam int countCap = 255;

// scan, report and release cycles
localparam int busyLen = 34;
localparam int resetCycles = 4;
localparam int stageTimeout = 200;
// scan cycles before the mid-stage reset
localparam int resetScanDelay = 2;

`endif

//--- tests/sifhTopTb.sv
`timescale 1ns/1ps

module sifhTopTb #(
    parameter int seed = 87
);
    import sifhPkg::*;

    `include "sifhRunTable.svh"

    logic             clk;
    logic             rstN;
    logic             wrEn;
    logic [codeW-1:0] roughData;
    logic             busy;
    logic             hisNum;
    logic             resultValid;
    peakResult_t      result;

    // reference histograms
    int coarseHist [numBins];
    int fineHist [numBins];
    // expected coarse peak, fine peak, window start
    int expCH;
    int expFH;
    int expStart;

    sifhTop sifhTop_inst (
        .clk(clk),
        .rstN(rstN),
        .wrEn(wrEn),
        .roughData(roughData),
        .busy(busy),
        .hisNum(hisNum),
        .resultValid(resultValid),
        .result(result)
    );

    // 100 ns period
    always begin
        #50 clk = ~clk;
    end

    task automatic failRun(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1);
    endtask

    // one stimulus code of a row
    function automatic logic [codeW-1:0] makeCode(input runRow_t row, input int idx);
        int value;
        value = row.target;
        // tie rows alternate between two targets
        if ((row.altStep != 0) && (idx % 2 == 1)) begin
            value = value + row.altStep;
        end
        if (row.spread != 0) begin
            value = value + int'($urandom_range(0, 2 * row.spread)) - row.spread;
        end
        if (int'($urandom_range(0, 99)) < row.noisePct) begin
            value = int'($urandom_range(0, codeSpan - 1));
        end
        if (value < 0) begin
            value = 0;
        end else if (value > codeSpan - 1) begin
            value = codeSpan - 1;
        end
        return codeW'(value);
    endfunction

    // strict compare so ties go to the lower bin
    function automatic int findPeak(input logic fine);
        int best;
        int bestIdx;
        int cnt;
        best = 0;
        bestIdx = 0;
        for (int b = 0; b < numBins; b++) begin
            cnt = fine ? fineHist[b] : coarseHist[b];
            if (cnt > best) begin
                best = cnt;
                bestIdx = b;
            end
        end
        return bestIdx;
    endfunction

    // half a window below the coarse peak bin and kept inside the code range
    function automatic int windowStart(input int peakBin);
        int start;
        start = peakBin * coarseSpan - halfWin;
        if (start < 0) begin
            start = 0;
        end else if (start > codeSpan - winLen) begin
            start = codeSpan - winLen;
        end
        return start;
    endfunction

    // drive acqLen codes and fill the reference histogram
    task automatic sendStage(input runRow_t row, input logic fine);
        logic [codeW-1:0] code;
        int bin;
        assert (hisNum == fine)
            else failRun($sformatf("MISMATCH hisNum got %h expected %h", hisNum, fine));
        for (int i = 0; i < acqLen; i++) begin
            assert (!busy) else failRun("busy rose before the stage had all its codes");
            code = makeCode(row, i);
            wrEn = 1'b1;
            roughData = code;
            if (!fine) begin
                bin = int'(code) / coarseSpan;
                if (coarseHist[bin] < countCap) begin
                    coarseHist[bin] += 1;
                end
            end else if ((int'(code) >= expStart) && (int'(code) < expStart + winLen)) begin
                // outside the window only the sample count moves
                bin = int'(code) - expStart;
                if (fineHist[bin] < countCap) begin
                    fineHist[bin] += 1;
                end
            end
            @(negedge clk);
        end
        wrEn = 1'b0;
    endtask

    task automatic checkResult();
        assert (int'(result.peakCH) == expCH)
            else failRun($sformatf("MISMATCH result.peakCH got %h expected %h",
                result.peakCH, binW'(expCH)));
        assert (int'(result.peakFH) == expFH)
            else failRun($sformatf("MISMATCH result.peakFH got %h expected %h",
                result.peakFH, binW'(expFH)));
        assert (int'(result.peakCode) == expStart + expFH)
            else failRun($sformatf("MISMATCH result.peakCode got %h expected %h",
                result.peakCode, codeW'(expStart + expFH)));
    endtask

    // scan phase bounded by stageTimeout
    task automatic finishStage(input logic fine, input bit inject);
        int busyCycles;
        int pulses;
        busyCycles = 0;
        pulses = 0;
        assert (busy) else failRun("busy did not rise after the last code of the stage");
        while (busy) begin
            assert (busyCycles < stageTimeout) else failRun("timeout waiting for busy to fall");
            if (resultValid) begin
                pulses++;
                // pulse sits in the last busy cycle
                assert (fine && (busyCycles == busyLen - 1))
                    else failRun("resultValid pulsed at the wrong time");
                checkResult();
            end
            busyCycles++;
            // junk strobes that must not be counted
            wrEn = inject;
            roughData = codeW'($urandom_range(0, codeSpan - 1));
            @(negedge clk);
        end
        wrEn = 1'b0;
        assert (busyCycles == busyLen)
            else failRun($sformatf("MISMATCH busy cycles got %h expected %h",
                busyCycles, busyLen));
        assert (pulses == (fine ? 1 : 0))
            else failRun($sformatf("MISMATCH resultValid pulses got %h expected %h",
                pulses, fine));
        assert (hisNum == !fine)
            else failRun($sformatf("MISMATCH hisNum got %h expected %h", hisNum, !fine));
    endtask

    task automatic playRow(input runRow_t row);
        for (int b = 0; b < numBins; b++) begin
            coarseHist[b] = 0;
            fineHist[b] = 0;
        end
        sendStage(row, 1'b0);
        finishStage(1'b0, row.inject);
        expCH = findPeak(1'b0);
        expStart = windowStart(expCH);
        sendStage(row, 1'b1);
        expFH = findPeak(1'b1);
        finishStage(1'b1, row.inject);
    endtask

    // full coarse stage then reset a few bins into the scan
    task automatic resetMidStage(input runRow_t row);
        for (int i = 0; i < acqLen; i++) begin
            wrEn = 1'b1;
            roughData = makeCode(row, i);
            @(negedge clk);
        end
        wrEn = 1'b0;
        repeat (resetScanDelay) @(negedge clk);
        assert (busy) else failRun("busy did not rise after the last code of the stage");
        rstN = 1'b0;
        repeat (resetCycles) @(negedge clk);
        assert (!busy && !hisNum && !resultValid)
            else failRun("busy, hisNum or resultValid was not cleared by reset");
        rstN = 1'b1;
    endtask

    initial begin
        void'($urandom(seed));
        clk = 1'b0;
        rstN = 1'b0;
        wrEn = 1'b0;
        roughData = '0;
        repeat (resetCycles) @(negedge clk);
        rstN = 1'b1;
        for (int r = 0; r < numRuns; r++) begin
            playRow(runTable[r]);
        end
        // stale counts in bin 15 would beat the peak of the next row
        resetMidStage(runTable[0]);
        // counters must restart clean after the reset
        playRow(runTable[3]);
        $display("test passed");
        $finish;
    end

endmodule

//--- sifhTop.f
+incdir+tests
hw/sifhPkg.sv
hw/binMapper.sv
hw/histogramBuilder.sv
hw/windowCalc.sv
hw/sifhTop.sv
tests/sifhTopTb.sv

//--- Makefile
# Verilator build and run for the sifhTop testbench

TOP      ?= sifhTopTb
SEED     ?= 87
FILELIST ?= sifhTop.f
OBJDIR   ?= obj_dir
VFLAGS   ?= --binary --timing --assert -j 0
PASSMSG  ?= test passed

.PHONY: all compile run clean

all: run

compile:
	verilator $(VFLAGS) --top-module $(TOP) -Gseed=$(SEED) \
		--Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASSMSG)"

clean:
	rm -rf $(OBJDIR)
